//--- all.f
logic/radar_pkg.sv
logic/stream_arbiter.sv
logic/shared_settings.sv
logic/core_regs.sv
logic/radar_block.sv
verif/radar_block_properties.sv
verif/tb_radar_block.sv

//--- run.sh
#!/bin/sh
# build and run the radar_block simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_radar_block -f all.f -o sim_radar
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_radar)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

//--- verif/tb_radar_block.sv
/*
 * testbench for radar_block
 * load now, scratch isolation, external forwarding, pps load, response back-pressure
 */
`timescale 1ns/1ns
`default_nettype none

module tb_radar_block;

  localparam int NC = 2;
  localparam int CW = 1;
  // per-test cycle budgets plus reset, summed for the watchdog
  localparam int RUN_CYCLES = 10 + 300 + 300 + 800 + 300 + 900 + 400;

  logic                clk;
  logic                rst_n;
  radar_pkg::set_req_t set_in [NC];
  logic [NC-1:0]       set_valid;
  logic [NC-1:0]       set_ready;
  logic                tick;
  logic                pps;
  logic [63:0]         vita_time;
  radar_pkg::set_req_t ext_set;
  logic                ext_valid;
  logic [CW-1:0]       ext_chan;
  logic                ext_ready;
  radar_pkg::resp_t    resp;
  logic                resp_valid;
  logic [CW-1:0]       resp_chan;
  logic                resp_ready;

  logic [31:0]         rng_state;
  logic                tick_en;
  // ready modes: 0 high, 1 low, 2 random
  int                  ext_mode;
  int                  resp_mode;
  int                  errors;
  int                  checks;
  int                  tests;
  longint              tick_cnt;
  logic [31:0]         scratch_val [NC];
  radar_pkg::resp_t    resp_q [$];
  logic [CW-1:0]       resp_chan_q [$];
  radar_pkg::set_req_t ext_q [$];
  logic [CW-1:0]       ext_chan_q [$];

  radar_block #(.NUM_CHANNELS(NC)) i_dut (
    .ce_clk (clk), .i_rst_n (rst_n),
    .i_set (set_in), .i_set_valid (set_valid), .o_set_ready (set_ready),
    .i_tick (tick), .i_pps (pps), .o_vita_time (vita_time),
    .o_ext_set (ext_set), .o_ext_valid (ext_valid), .o_ext_chan (ext_chan),
    .i_ext_ready (ext_ready),
    .o_resp (resp), .o_resp_valid (resp_valid), .o_resp_chan (resp_chan),
    .i_resp_ready (resp_ready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic rnd_bit();
    rng_state = xorshift32(rng_state);
    return rng_state[9];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // random tick and ready drivers, monitors
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    #10;
    tick       = tick_en & rnd_bit();
    ext_ready  = (ext_mode == 0) ? 1'b1 : (ext_mode == 1) ? 1'b0 : rnd_bit();
    resp_ready = (resp_mode == 0) ? 1'b1 : (resp_mode == 1) ? 1'b0 : rnd_bit();
  end

  // sampled at the edge, before the DUT updates
  always @(posedge clk) begin
    if (tick) tick_cnt++;
    if (resp_valid && resp_ready) begin
      resp_q.push_back(resp);
      resp_chan_q.push_back(resp_chan);
    end
    if (ext_valid && ext_ready) begin
      ext_q.push_back(ext_set);
      ext_chan_q.push_back(ext_chan);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  task automatic report_error(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  // holds valid until the edge where ready was seen
  task automatic send(input int ch, input logic [7:0] a, input logic [31:0] d);
    logic rdy;
    int   n;
    set_in[ch].addr = a;
    set_in[ch].data = d;
    set_valid[ch]   = 1'b1;
    n = 0;
    do begin
      rdy = set_ready[ch];
      cycles(1);
      n++;
    end while (!rdy && n < 200);
    set_valid[ch] = 1'b0;
    if (!rdy) report_error($sformatf("settings write on channel %0d never accepted", ch));
  endtask

  task automatic wait_resp(input int count);
    int n;
    n = 0;
    while (resp_q.size() < count && n < 300) begin
      cycles(1);
      n++;
    end
    if (resp_q.size() < count) report_error("timed out waiting for a readback response");
  endtask

  task automatic wait_ext(input int count);
    int n;
    n = 0;
    while (ext_q.size() < count && n < 300) begin
      cycles(1);
      n++;
    end
    if (ext_q.size() < count) report_error("timed out waiting for external writes");
  endtask

  task automatic wait_time(input logic [63:0] v);
    int n;
    n = 0;
    while (vita_time < v && n < 100) begin
      cycles(1);
      n++;
    end
    if (vita_time < v) report_error("timed out waiting for the time load");
  endtask

  task automatic check_time_range(input logic [63:0] lo, input longint t0);
    logic [63:0] hi;
    hi = lo + 64'(tick_cnt - t0);
    checks++;
    assert (vita_time >= lo && vita_time <= hi) else begin
      errors++;
      $display("mismatch at %0t: o_vita_time expected %h..%h actual %h", $time, lo, hi,
               vita_time);
    end
  endtask

  // one scratch response per channel, then clear
  task automatic check_scratch_resps();
    int seen [NC];
    foreach (seen[c]) seen[c] = 0;
    foreach (resp_q[i]) begin
      seen[resp_chan_q[i]]++;
      check_val("o_resp.addr", 64'(radar_pkg::RB_SCRATCH), 64'(resp_q[i].addr));
      check_val("o_resp.data", {32'h0, scratch_val[resp_chan_q[i]]}, resp_q[i].data);
    end
    foreach (seen[c]) check_val("o_resp_chan count", 64'd1, 64'(seen[c]));
    resp_q.delete();
    resp_chan_q.delete();
  endtask

  task automatic scratch_readback_all();
    for (int c = 0; c < NC; c++) begin
      fork
        automatic int ch = c;
        send(ch, radar_pkg::SR_RB_ADDR, 32'(radar_pkg::RB_SCRATCH));
      join_none
    end
    wait fork;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s finished, errors so far %0d", tests, name, errors);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [63:0] staged;
    logic [63:0] prev_staged;
    longint      t0;
    int          next_k [NC];
    int          c;

    clk = 1'b0;
    rst_n = 1'b0;
    set_valid = '0;
    foreach (set_in[i]) set_in[i] = '0;
    tick = 1'b0;
    pps = 1'b0;
    ext_ready = 1'b1;
    resp_ready = 1'b1;
    ext_mode = 0;
    resp_mode = 0;
    tick_en = 1'b0;
    rng_state = 32'h2975;
    errors = 0;
    checks = 0;
    tests = 0;
    tick_cnt = 0;
    repeat (10) @(posedge clk);
    #10;
    rst_n = 1'b1;
    cycles(2);

    // load now
    tick_en = 1'b1;
    staged = 64'h0000_0123_0000_0040;
    send(0, radar_pkg::SR_TIME_HI, staged[63:32]);
    send(0, radar_pkg::SR_TIME_LO, staged[31:0]);
    send(0, radar_pkg::SR_TIME_CTRL, 32'h1);
    t0 = tick_cnt;
    wait_time(staged);
    check_time_range(staged, t0);
    end_test("load now");

    // scratch isolation
    foreach (scratch_val[i]) scratch_val[i] = 32'hA500_0000 ^ (i << 8) ^ xorshift32(i + 1);
    for (int k = 0; k < NC; k++) begin
      fork
        automatic int ch = k;
        send(ch, radar_pkg::SR_SCRATCH, scratch_val[ch]);
      join_none
    end
    wait fork;
    scratch_readback_all();
    wait_resp(NC);
    cycles(5);
    check_val("response count", 64'(NC), 64'(resp_q.size()));
    check_scratch_resps();
    end_test("scratch isolation");

    // external forwarding, even k external, odd k internal
    ext_mode = 2;
    for (int k = 0; k < NC; k++) begin
      fork
        automatic int ch = k;
        for (int j = 0; j < 6; j++) begin
          if (j % 2 == 0) send(ch, 8'(192 + j), {8'(ch), 24'(j)});
          else send(ch, 8'(150 + j), 32'hDEAD_0000);
        end
      join_none
    end
    wait fork;
    wait_ext(NC * 3);
    cycles(5);
    check_val("external write count", 64'(NC * 3), 64'(ext_q.size()));
    foreach (next_k[i]) next_k[i] = 0;
    foreach (ext_q[i]) begin
      c = ext_chan_q[i];
      check_val("o_ext_set.addr", 64'(192 + 2 * next_k[c]), 64'(ext_q[i].addr));
      check_val("o_ext_set.data", 64'({8'(c), 24'(2 * next_k[c])}), 64'(ext_q[i].data));
      next_k[c]++;
    end
    ext_mode = 0;
    end_test("external forwarding");

    // armed pps load
    prev_staged = staged;
    staged = 64'h0000_0456_0000_0000;
    send(1, radar_pkg::SR_TIME_HI, staged[63:32]);
    send(1, radar_pkg::SR_TIME_LO, staged[31:0]);
    send(1, radar_pkg::SR_TIME_CTRL, 32'h2);
    repeat (8) begin
      cycles(1);
      checks++;
      assert (vita_time < staged) else begin
        errors++;
        $display("mismatch at %0t: o_vita_time expected below %h actual %h", $time, staged,
                 vita_time);
      end
    end
    t0 = tick_cnt;
    pps = 1'b1;
    cycles(2);
    pps = 1'b0;
    wait_time(staged);
    check_time_range(staged, t0);
    send(0, radar_pkg::SR_RB_ADDR, 32'(radar_pkg::RB_LASTPPS));
    wait_resp(1);
    if (resp_q.size() > 0) begin
      check_val("o_resp.addr", 64'(radar_pkg::RB_LASTPPS), 64'(resp_q[0].addr));
      check_val("o_resp_chan", 64'd0, 64'(resp_chan_q[0]));
      checks++;
      // time before the pps load, counted up from the first load
      assert (resp_q[0].data >= prev_staged && resp_q[0].data < staged) else begin
        errors++;
        $display("mismatch at %0t: o_resp.data expected %h..%h actual %h", $time,
                 prev_staged, staged - 64'd1, resp_q[0].data);
      end
    end
    resp_q.delete();
    resp_chan_q.delete();
    end_test("pps load");

    // response back-pressure, one request per channel per round
    for (int r = 0; r < 3; r++) begin
      resp_mode = 1;
      scratch_readback_all();
      cycles(8);
      check_val("responses taken while held", 64'd0, 64'(resp_q.size()));
      resp_mode = 2;
      wait_resp(NC);
      cycles(10);
      check_val("response count", 64'(NC), 64'(resp_q.size()));
      check_scratch_resps();
    end
    resp_mode = 0;
    end_test("response back-pressure");

    errors += i_dut.u_props.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(longint'(RUN_CYCLES) * 100);
    $display("error: run exceeded its time budget");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/radar_block_properties.sv
/*
 * concurrent checks on the radar control-plane outputs
 * stream stability, post-reset valids, monotonic vita time
 */
`timescale 1ns/1ns
`default_nettype none

module radar_block_properties (
  input  logic                         ce_clk,
  input  logic                         i_rst_n,
  input  radar_pkg::resp_t             o_resp,
  input  logic                         o_resp_valid,
  input  logic                         i_resp_ready,
  input  radar_pkg::set_req_t          o_ext_set,
  input  logic                         o_ext_valid,
  input  logic                         i_ext_ready,
  input  logic [radar_pkg::TIME_W-1:0] o_vita_time,
  input  radar_pkg::set_req_t          i_mux,
  input  logic                         i_mux_valid,
  input  logic                         i_pps
);

  int   fail_cnt = 0;
  logic load_evt;

  // anything that may move the time backwards
  assign load_evt = (i_mux_valid && i_mux.addr == radar_pkg::SR_TIME_CTRL) || i_pps;

  //////////////////////////////////////////////////////////////////////
  // stream stability under back-pressure
  //////////////////////////////////////////////////////////////////////
  a_resp_stable: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp))
    else begin
      fail_cnt++;
      $error("response changed while waiting");
    end

  a_ext_stable: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    o_ext_valid && !i_ext_ready |=> o_ext_valid && $stable(o_ext_set))
    else begin
      fail_cnt++;
      $error("external write changed while waiting");
    end

  // first cycle out of reset
  a_reset_idle: assert property (@(posedge ce_clk)
    i_rst_n && $past(!i_rst_n) |-> !o_resp_valid && !o_ext_valid)
    else begin
      fail_cnt++;
      $error("valid output high right after reset");
    end

  // time only steps back on a load
  a_time_mono: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    o_vita_time < $past(o_vita_time) |-> $past(load_evt))
    else begin
      fail_cnt++;
      $error("vita time decreased without a load");
    end

endmodule

bind radar_block radar_block_properties u_props (
  .ce_clk       (ce_clk),
  .i_rst_n      (i_rst_n),
  .o_resp       (o_resp),
  .o_resp_valid (o_resp_valid),
  .i_resp_ready (i_resp_ready),
  .o_ext_set    (o_ext_set),
  .o_ext_valid  (o_ext_valid),
  .i_ext_ready  (i_ext_ready),
  .o_vita_time  (o_vita_time),
  .i_mux        (set_mux),
  .i_mux_valid  (set_mux_valid),
  .i_pps        (i_pps)
);

`default_nettype wire

//--- logic/radar_block.sv
/*
 * radar control-plane top level
 * settings arbiter, shared timekeeper, per-channel regs, response arbiter
 */
`timescale 1ns/1ns
`default_nettype none

module radar_block #(
  parameter int  NUM_CHANNELS = 2,
  localparam int CHAN_W       = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
  input  logic                         ce_clk,
  input  logic                         i_rst_n,
  // per-channel settings buses
  input  radar_pkg::set_req_t          i_set [NUM_CHANNELS],
  input  logic [NUM_CHANNELS-1:0]      i_set_valid,
  output logic [NUM_CHANNELS-1:0]      o_set_ready,
  // time base
  input  logic                         i_tick,
  input  logic                         i_pps,
  output logic [radar_pkg::TIME_W-1:0] o_vita_time,
  // external settings port
  output radar_pkg::set_req_t          o_ext_set,
  output logic                         o_ext_valid,
  output logic [CHAN_W-1:0]            o_ext_chan,
  input  logic                         i_ext_ready,
  // merged readback responses
  output radar_pkg::resp_t             o_resp,
  output logic                         o_resp_valid,
  output logic [CHAN_W-1:0]            o_resp_chan,
  input  logic                         i_resp_ready
);

  radar_pkg::set_req_t          set_mux;
  logic                         set_mux_valid;
  logic                         set_mux_ready;
  logic [CHAN_W-1:0]            set_mux_src;
  logic [radar_pkg::TIME_W-1:0] vita_lastpps;
  radar_pkg::resp_t             core_resp [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0]      core_resp_valid;
  logic [NUM_CHANNELS-1:0]      core_resp_ready;

  //////////////////////////////////////////////////////////////////////
  // settings path
  //////////////////////////////////////////////////////////////////////
  stream_arbiter #(
    .NUM_INPUTS (NUM_CHANNELS),
    .T_PAYLOAD  (radar_pkg::set_req_t)
  ) u_set_arb (
    .ce_clk      (ce_clk),
    .i_rst_n     (i_rst_n),
    .i_in        (i_set),
    .i_in_valid  (i_set_valid),
    .o_in_ready  (o_set_ready),
    .o_out       (set_mux),
    .o_out_valid (set_mux_valid),
    .i_out_ready (set_mux_ready),
    .o_out_src   (set_mux_src)
  );

  // time base shared by all channels
  shared_settings #(
    .NUM_INPUTS (NUM_CHANNELS)
  ) u_shared (
    .ce_clk         (ce_clk),
    .i_rst_n        (i_rst_n),
    .i_set          (set_mux),
    .i_set_valid    (set_mux_valid),
    .i_set_src      (set_mux_src),
    .o_set_ready    (set_mux_ready),
    .i_tick         (i_tick),
    .i_pps          (i_pps),
    .o_vita_time    (o_vita_time),
    .o_vita_lastpps (vita_lastpps),
    .o_ext_set      (o_ext_set),
    .o_ext_valid    (o_ext_valid),
    .o_ext_chan     (o_ext_chan),
    .i_ext_ready    (i_ext_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // per-channel regs, snooping the arbiter input handshake
  //////////////////////////////////////////////////////////////////////
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    core_regs u_core_regs (
      .ce_clk         (ce_clk),
      .i_rst_n        (i_rst_n),
      .i_set          (i_set[c]),
      .i_set_valid    (i_set_valid[c]),
      .i_set_ready    (o_set_ready[c]),
      .i_vita_time    (o_vita_time),
      .i_vita_lastpps (vita_lastpps),
      .o_resp         (core_resp[c]),
      .o_resp_valid   (core_resp_valid[c]),
      .i_resp_ready   (core_resp_ready[c])
    );
  end

  // response merge
  stream_arbiter #(
    .NUM_INPUTS (NUM_CHANNELS),
    .T_PAYLOAD  (radar_pkg::resp_t)
  ) u_resp_arb (
    .ce_clk      (ce_clk),
    .i_rst_n     (i_rst_n),
    .i_in        (core_resp),
    .i_in_valid  (core_resp_valid),
    .o_in_ready  (core_resp_ready),
    .o_out       (o_resp),
    .o_out_valid (o_resp_valid),
    .i_out_ready (i_resp_ready),
    .o_out_src   (o_resp_chan)
  );

endmodule

`default_nettype wire

//--- logic/core_regs.sv
/*
 * per-channel register block
 * scratch register and single-entry readback response
 */
`timescale 1ns/1ns
`default_nettype none

module core_regs (
  input  logic                         ce_clk,
  input  logic                         i_rst_n,
  input  radar_pkg::set_req_t          i_set,
  input  logic                         i_set_valid,
  input  logic                         i_set_ready,
  input  logic [radar_pkg::TIME_W-1:0] i_vita_time,
  input  logic [radar_pkg::TIME_W-1:0] i_vita_lastpps,
  output radar_pkg::resp_t             o_resp,
  output logic                         o_resp_valid,
  input  logic                         i_resp_ready
);

  logic                         set_fire;
  logic                         rb_req;
  logic                         rb_start;
  logic [radar_pkg::ADDR_W-1:0] rb_sel;
  logic [radar_pkg::TIME_W-1:0] rb_data;
  logic [radar_pkg::DATA_W-1:0] scratch_q;

  // same handshake the settings arbiter sees
  assign set_fire = i_set_valid && i_set_ready;
  assign rb_req   = set_fire && (i_set.addr == radar_pkg::SR_RB_ADDR);
  // low data bits pick the source
  assign rb_sel   = i_set.data[radar_pkg::ADDR_W-1:0];
  // requests during a pending response are lost
  assign rb_start = rb_req && !o_resp_valid;

  //////////////////////////////////////////////////////////////////////
  // readback source select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (rb_sel)
      radar_pkg::RB_VITA_TIME: rb_data = i_vita_time;
      radar_pkg::RB_LASTPPS:   rb_data = i_vita_lastpps;
      // scratch zero-extended to readback width
      radar_pkg::RB_SCRATCH: begin
        rb_data = {{(radar_pkg::TIME_W - radar_pkg::DATA_W){1'b0}}, scratch_q};
      end
      default:                 rb_data = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      scratch_q    <= '0;
      o_resp_valid <= 1'b0;
    end else begin
      if (set_fire && i_set.addr == radar_pkg::SR_SCRATCH) begin
        scratch_q <= i_set.data;
      end
      // held until the response arbiter takes it
      if (rb_start) begin
        o_resp_valid <= 1'b1;
      end else if (o_resp_valid && i_resp_ready) begin
        o_resp_valid <= 1'b0;
      end
    end
  end

  // response payload, sampled at the request
  always_ff @(posedge ce_clk) begin
    if (rb_start) begin
      o_resp.addr <= rb_sel;
      o_resp.data <= rb_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/shared_settings.sv
/*
 * shared consumer of the arbitrated settings bus
 * vita timekeeper with pps latch, and external settings forwarding
 */
`timescale 1ns/1ns
`default_nettype none

module shared_settings #(
  parameter int  NUM_INPUTS = 2,
  localparam int CHAN_W     = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
  input  logic                            ce_clk,
  input  logic                            i_rst_n,
  input  radar_pkg::set_req_t             i_set,
  input  logic                            i_set_valid,
  input  logic [CHAN_W-1:0]               i_set_src,
  output logic                            o_set_ready,
  input  logic                            i_tick,
  input  logic                            i_pps,
  output logic [radar_pkg::TIME_W-1:0]    o_vita_time,
  output logic [radar_pkg::TIME_W-1:0]    o_vita_lastpps,
  output radar_pkg::set_req_t             o_ext_set,
  output logic                            o_ext_valid,
  output logic [CHAN_W-1:0]               o_ext_chan,
  input  logic                            i_ext_ready
);

  logic                         is_ext;
  logic                         int_fire;
  logic                         ctrl_wr;
  logic                         load_now;
  logic                         arm_wr;
  logic                         load_pps;
  logic                         time_load;
  logic                         arm_q;
  logic                         pps_q;
  logic                         pps_rise;
  logic [radar_pkg::DATA_W-1:0] time_hi_q;
  logic [radar_pkg::DATA_W-1:0] time_lo_q;

  //////////////////////////////////////////////////////////////////////
  // bus decode
  //////////////////////////////////////////////////////////////////////
  assign is_ext = i_set.addr >= radar_pkg::SR_EXTERNAL_BASE;
  // internal writes always absorbed, external ones wait on the port
  assign o_set_ready = !is_ext || i_ext_ready;
  assign int_fire    = i_set_valid && !is_ext;
  assign ctrl_wr     = int_fire && (i_set.addr == radar_pkg::SR_TIME_CTRL);
  assign load_now    = ctrl_wr && i_set.data[0];
  assign arm_wr      = ctrl_wr && i_set.data[1];

  // external port, arbiter output already holds steady
  assign o_ext_set   = i_set;
  assign o_ext_valid = i_set_valid && is_ext;
  assign o_ext_chan  = i_set_src;

  //////////////////////////////////////////////////////////////////////
  // timekeeper
  //////////////////////////////////////////////////////////////////////
  assign pps_rise  = i_pps && !pps_q;
  assign load_pps  = pps_rise && arm_q;
  assign time_load = load_now || load_pps;

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      pps_q          <= 1'b0;
      arm_q          <= 1'b0;
      time_hi_q      <= '0;
      time_lo_q      <= '0;
      o_vita_time    <= '0;
      o_vita_lastpps <= '0;
    end else begin
      pps_q <= i_pps;
      if (int_fire && i_set.addr == radar_pkg::SR_TIME_HI) begin
        time_hi_q <= i_set.data;
      end
      if (int_fire && i_set.addr == radar_pkg::SR_TIME_LO) begin
        time_lo_q <= i_set.data;
      end
      // a fresh arm wins over the edge that clears it
      if (arm_wr) begin
        arm_q <= 1'b1;
      end else if (load_pps) begin
        arm_q <= 1'b0;
      end
      // loads override the tick count
      if (time_load) begin
        o_vita_time <= {time_hi_q, time_lo_q};
      end else if (i_tick) begin
        o_vita_time <= o_vita_time + 1'b1;
      end
      // time just before the edge
      if (pps_rise) begin
        o_vita_lastpps <= o_vita_time;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/stream_arbiter.sv
/*
 * round-robin valid/ready arbiter
 * one holding buffer per input, registered output tagged with source
 */
`timescale 1ns/1ns
`default_nettype none

module stream_arbiter #(
  parameter int  NUM_INPUTS = 2,
  parameter type T_PAYLOAD  = logic,
  localparam int IDX_W      = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
  input  logic                  ce_clk,
  input  logic                  i_rst_n,
  input  T_PAYLOAD              i_in [NUM_INPUTS],
  input  logic [NUM_INPUTS-1:0] i_in_valid,
  output logic [NUM_INPUTS-1:0] o_in_ready,
  output T_PAYLOAD              o_out,
  output logic                  o_out_valid,
  input  logic                  i_out_ready,
  output logic [IDX_W-1:0]      o_out_src
);

  T_PAYLOAD              buf_q [NUM_INPUTS];
  logic [NUM_INPUTS-1:0] buf_vld;
  logic [NUM_INPUTS-1:0] in_accept;
  logic [IDX_W-1:0]      last_q;
  logic [IDX_W-1:0]      pick_idx;
  logic                  pick_vld;
  logic                  out_load;
  logic                  take;

  // input side, ready while the slot is empty
  assign o_in_ready = ~buf_vld;
  assign in_accept  = i_in_valid & o_in_ready;

  // output reg free when empty or draining this cycle
  assign out_load = !o_out_valid || i_out_ready;
  assign take     = out_load && pick_vld;

  // search starts one past the last grant
  always_comb begin
    int unsigned cand;
    pick_vld = 1'b0;
    pick_idx = last_q;
    for (int k = 1; k <= NUM_INPUTS; k++) begin
      cand = (int'(last_q) + k) % NUM_INPUTS;
      if (!pick_vld && buf_vld[cand]) begin
        pick_vld = 1'b1;
        pick_idx = IDX_W'(cand);
      end
    end
  end

  // payload path
  always_ff @(posedge ce_clk) begin
    for (int n = 0; n < NUM_INPUTS; n++) begin
      if (in_accept[n]) begin
        buf_q[n] <= i_in[n];
      end
    end
    if (take) begin
      o_out     <= buf_q[pick_idx];
      o_out_src <= pick_idx;
    end
  end

  // control path
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      buf_vld     <= '0;
      o_out_valid <= 1'b0;
      // first search then begins at input 0
      last_q      <= IDX_W'(NUM_INPUTS - 1);
    end else begin
      for (int n = 0; n < NUM_INPUTS; n++) begin
        // a slot never fills and drains in one cycle
        if (in_accept[n]) begin
          buf_vld[n] <= 1'b1;
        end else if (take && pick_idx == IDX_W'(n)) begin
          buf_vld[n] <= 1'b0;
        end
      end
      if (out_load) begin
        o_out_valid <= pick_vld;
      end
      if (take) begin
        last_q <= pick_idx;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/radar_pkg.sv
/*
 * shared settings-bus constants for the radar control plane
 * register map, readback selectors and the payload structs
 */
`default_nettype none

package radar_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  // vita time and readback data
  localparam int TIME_W = 64;

  //////////////////////////////////////////////////////////////////////
  // settings register map
  //////////////////////////////////////////////////////////////////////
  // time staging words, loaded as {hi, lo}
  localparam logic [ADDR_W-1:0] SR_TIME_HI       = 8'd128;
  localparam logic [ADDR_W-1:0] SR_TIME_LO       = 8'd129;
  // bit 0 load now, bit 1 arm load on next pps
  localparam logic [ADDR_W-1:0] SR_TIME_CTRL     = 8'd130;
  // per-channel registers
  localparam logic [ADDR_W-1:0] SR_RB_ADDR       = 8'd140;
  localparam logic [ADDR_W-1:0] SR_SCRATCH       = 8'd141;
  // everything from here up leaves the block
  localparam logic [ADDR_W-1:0] SR_EXTERNAL_BASE = 8'd192;

  // readback source selectors, low data bits of SR_RB_ADDR
  localparam logic [ADDR_W-1:0] RB_VITA_TIME = 8'd0;
  localparam logic [ADDR_W-1:0] RB_LASTPPS   = 8'd1;
  localparam logic [ADDR_W-1:0] RB_SCRATCH   = 8'd2;

  //////////////////////////////////////////////////////////////////////
  // payloads
  //////////////////////////////////////////////////////////////////////
  // one settings write, 40 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } set_req_t;

  // one readback response, 72 bits
  // addr echoes the selector that was requested
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [TIME_W-1:0] data;
  } resp_t;

endpackage

`default_nettype wire
